// File: tb.f
+incdir+include
design/sift_types_pkg.sv
design/sift_packet_pkg.sv
design/qubit_word_if.sv
design/sift_control.sv
design/qubit_reader.sv
design/decoy_packet_writer.sv
design/key_sifter.sv
design/qkd_sift_top.sv
dv/tb_qkd_sift.sv

// File: Makefile
TOP := tb_qkd_sift

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/tb_qkd_sift.sv
`include "sift_params.svh"

module tb_qkd_sift;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WORDS = `SIFT_WORDS_PER_ROUND;
    localparam int ROUNDS = `SIFT_ROUNDS;
    localparam int RUNS = 2;
    localparam int PKT_WORDS = WORDS + 1;
    localparam int QMEM_DEPTH = 128;
    localparam int HOLD_CYCLES = 12;
    localparam int STALL_DRAIN = 3;
    // per run budget, plus the slow drain of run two and the held phases
    localparam int WATCHDOG_CYCLES = RUNS * (ROUNDS * (WORDS + 8) + 50)
        + ROUNDS * PKT_WORDS * STALL_DRAIN + RUNS * (HOLD_CYCLES + 20) + 200;

    logic clk;
    logic rst_n;
    logic start_sifting;
    logic start_tx;
    logic detect_fifo_full;
    logic tx_empty = 1'b1;
    sift_types_pkg::qubit_word_t qubit_rdata = '0;
    sift_types_pkg::slot_mask_t detected_rd_data;
    logic wait_tx;
    logic sifting_finish;
    sift_types_pkg::mem_addr_t qubit_addr;
    logic detected_rd_en;
    logic tx_wr_en;
    logic [31:0] tx_wr_data;
    logic key_wr_en;
    sift_types_pkg::mem_addr_t key_addr;
    sift_types_pkg::key_word_t key_wr_data;

    sift_types_pkg::qubit_word_t qmem [QMEM_DEPTH];
    sift_types_pkg::slot_mask_t dfifo [256];
    logic [7:0] dptr = '0;
    logic [31:0] tx_exp [$];
    sift_types_pkg::key_word_t key_exp [$];
    int key_per_run [RUNS];
    sift_types_pkg::key_word_t key_acc = '0;
    int key_fill = 0;
    int tx_idx = 0;
    int key_idx = 0;
    int pop_count = 0;
    int finish_count = 0;
    logic finish_q = 1'b0;
    int tx_level = 0;
    int tx_seen = 0;
    int drain_cnt = 0;
    int drain_period = 1;

    qkd_sift_top dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .start_sifting    (start_sifting),
        .start_tx         (start_tx),
        .detect_fifo_full (detect_fifo_full),
        .tx_empty         (tx_empty),
        .qubit_rdata      (qubit_rdata),
        .detected_rd_data (detected_rd_data),
        .wait_tx          (wait_tx),
        .sifting_finish   (sifting_finish),
        .qubit_addr       (qubit_addr),
        .detected_rd_en   (detected_rd_en),
        .tx_wr_en         (tx_wr_en),
        .tx_wr_data       (tx_wr_data),
        .key_wr_en        (key_wr_en),
        .key_addr         (key_addr),
        .key_wr_data      (key_wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // slot i is a decoy when both of its pulse bits are set
    function automatic sift_types_pkg::slot_mask_t decoy_mask(
        input sift_types_pkg::qubit_word_t q
    );
        sift_types_pkg::slot_mask_t m;
        for (int i = 0; i < `SIFT_SLOTS; i++) begin
            m[i] = (q[2*i +: 2] != 2'b11);
        end
        return m;
    endfunction

    // type, length, round from the top byte down
    function automatic logic [31:0] header_word(input int round);
        logic [7:0] pkt_type;
        logic [7:0] pkt_len;
        pkt_type = `SIFT_PKT_DECOY;
        pkt_len = 8'(`SIFT_PKT_LENGTH);
        return {pkt_type, pkt_len, 16'(round)};
    endfunction

    // kept low pulse bits in slot order, first bit lands in the msb
    function automatic void append_key_bits(
        input sift_types_pkg::qubit_word_t q,
        input sift_types_pkg::slot_mask_t det
    );
        sift_types_pkg::slot_mask_t nd;
        nd = decoy_mask(q);
        for (int i = `SIFT_SLOTS - 1; i >= 0; i--) begin
            if (nd[i] && det[i]) begin
                key_acc = {key_acc[62:0], q[2*i]};
                key_fill++;
                if (key_fill == 64) begin
                    key_exp.push_back(key_acc);
                    key_fill = 0;
                end
            end
        end
    endfunction

    always @(posedge clk) begin
        qubit_rdata <= qmem[qubit_addr[6:0]];
    end

    // first word fall through, pop on the clock edge
    assign detected_rd_data = dfifo[dptr];

    always @(posedge clk) begin
        if (detected_rd_en) begin
            dptr <= dptr + 8'd1;
        end
    end

    // TX FIFO fill level, one word leaves every drain_period cycles
    always @(negedge clk) begin
        if (tx_wr_en) begin
            assert (tx_seen % PKT_WORDS != 0 || tx_level == 0)
                else report_failure("packet header written while the TX FIFO was not empty");
            tx_seen++;
            tx_level++;
        end
        if (tx_level > 0) begin
            drain_cnt++;
            if (drain_cnt >= drain_period) begin
                tx_level--;
                drain_cnt = 0;
            end
        end
        tx_empty = (tx_level == 0);
    end

    always @(negedge clk) begin
        if (rst_n) begin
            if (tx_wr_en) begin
                assert (tx_idx < tx_exp.size())
                    else report_failure("TX write beyond the expected packets");
                assert (tx_wr_data == tx_exp[tx_idx])
                    else report_failure($sformatf("Error tx_wr_data expected %h got %h",
                        tx_exp[tx_idx], tx_wr_data));
                tx_idx++;
            end
            if (key_wr_en) begin
                assert (key_idx < key_exp.size())
                    else report_failure("key write beyond the expected key stream");
                assert (key_addr == sift_types_pkg::mem_addr_t'(key_idx))
                    else report_failure($sformatf("Error key_addr expected %h got %h",
                        key_idx, key_addr));
                assert (key_wr_data == key_exp[key_idx])
                    else report_failure($sformatf("Error key_wr_data expected %h got %h",
                        key_exp[key_idx], key_wr_data));
                key_idx++;
            end
            if (detected_rd_en) begin
                pop_count++;
            end
            if (sifting_finish) begin
                assert (!finish_q)
                    else report_failure("sifting_finish lasted more than one cycle");
                finish_count++;
                assert (finish_count <= RUNS)
                    else report_failure("sifting_finish pulsed more often than runs started");
                assert (tx_idx == finish_count * ROUNDS * PKT_WORDS)
                    else report_failure($sformatf("Error tx writes expected %h got %h",
                        finish_count * ROUNDS * PKT_WORDS, tx_idx));
                assert (pop_count == finish_count * ROUNDS * WORDS)
                    else report_failure($sformatf("Error detected_rd_en expected %h got %h",
                        finish_count * ROUNDS * WORDS, pop_count));
                assert (key_idx == key_per_run[finish_count-1])
                    else report_failure($sformatf("Error key writes expected %h got %h",
                        key_per_run[finish_count-1], key_idx));
            end
            finish_q = sifting_finish;
        end
    end

    task automatic run_sifting(input int hold);
        start_sifting = 1'b1;
        @(negedge clk);
        start_sifting = 1'b0;
        // receiver buffer still filling
        repeat (8) begin
            @(negedge clk);
            assert (!wait_tx)
                else report_failure("wait_tx rose before the detection FIFO was full");
        end
        detect_fifo_full = 1'b1;
        for (int i = 0; i < 4 && !wait_tx; i++) begin
            @(negedge clk);
        end
        assert (wait_tx)
            else report_failure("wait_tx did not rise after the detection FIFO filled");
        // go-ahead withheld, nothing may move
        repeat (hold) begin
            @(negedge clk);
            assert (wait_tx && !tx_wr_en && !detected_rd_en && !key_wr_en)
                else report_failure("DUT became active while start_tx was withheld");
        end
        start_tx = 1'b1;
        @(negedge clk);
        start_tx = 1'b0;
        detect_fifo_full = 1'b0;
        // run ends with the finish pulse, idle again one cycle later
        while (!sifting_finish) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    initial begin
        logic [31:0] rng;
        logic [31:0] hi;
        int pops;
        int addr;
        rst_n = 1'b0;
        start_sifting = 1'b0;
        start_tx = 1'b0;
        detect_fifo_full = 1'b0;
        // qubit memory and detection FIFO from one xorshift stream
        rng = 32'h0a58_c80e;
        for (int a = 0; a < QMEM_DEPTH; a++) begin
            rng = xorshift32(rng);
            hi = rng;
            rng = xorshift32(rng);
            qmem[a] = {hi, rng};
        end
        for (int a = 0; a < 256; a++) begin
            rng = xorshift32(rng);
            dfifo[a] = rng;
        end
        // every run rereads the same qubit words, the FIFO keeps advancing
        pops = 0;
        for (int n = 0; n < RUNS; n++) begin
            for (int r = 0; r < ROUNDS; r++) begin
                tx_exp.push_back(header_word(r));
                for (int w = 0; w < WORDS; w++) begin
                    addr = r * WORDS + w;
                    tx_exp.push_back(decoy_mask(qmem[addr]));
                    append_key_bits(qmem[addr], dfifo[pops]);
                    pops++;
                end
            end
            key_per_run[n] = key_exp.size();
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        assert (!wait_tx && !sifting_finish && !detected_rd_en && !tx_wr_en && !key_wr_en)
            else report_failure("outputs were not low after reset");
        run_sifting(HOLD_CYCLES);
        // slow drain so each round waits on tx_empty
        drain_period = STALL_DRAIN;
        run_sifting(HOLD_CYCLES);
        repeat (10) @(negedge clk);
        assert (finish_count == RUNS && tx_idx == tx_exp.size() && key_idx == key_exp.size())
            else report_failure("run ended with missing TX writes, key writes or finish pulses");
        $display("Done: no errors");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_failure("watchdog expired before both sifting runs finished");
    end

endmodule

// File: design/qkd_sift_top.sv
module qkd_sift_top (
    input  logic clk,
    input  logic rst_n,
    input  logic start_sifting,
    input  logic start_tx,
    input  logic detect_fifo_full,
    input  logic tx_empty,
    input  sift_types_pkg::qubit_word_t qubit_rdata,
    input  sift_types_pkg::slot_mask_t detected_rd_data,
    output logic wait_tx,
    output logic sifting_finish,
    output sift_types_pkg::mem_addr_t qubit_addr,
    output logic detected_rd_en,
    output logic tx_wr_en,
    output logic [31:0] tx_wr_data,
    output logic key_wr_en,
    output sift_types_pkg::mem_addr_t key_addr,
    output sift_types_pkg::key_word_t key_wr_data
);

    logic run;
    logic rounds_done;

    qubit_word_if words ();

    sift_control u_control (
        .clk              (clk),
        .rst_n            (rst_n),
        .start_sifting    (start_sifting),
        .start_tx         (start_tx),
        .detect_fifo_full (detect_fifo_full),
        .rounds_done      (rounds_done),
        .wait_tx          (wait_tx),
        .run              (run),
        .sifting_finish   (sifting_finish)
    );

    qubit_reader u_reader (
        .clk              (clk),
        .rst_n            (rst_n),
        .run              (run),
        .tx_empty         (tx_empty),
        .qubit_rdata      (qubit_rdata),
        .detected_rd_data (detected_rd_data),
        .qubit_addr       (qubit_addr),
        .detected_rd_en   (detected_rd_en),
        .rounds_done      (rounds_done),
        .words            (words.source)
    );

    decoy_packet_writer u_packet (
        .clk        (clk),
        .rst_n      (rst_n),
        .words      (words.sink),
        .tx_wr_en   (tx_wr_en),
        .tx_wr_data (tx_wr_data)
    );

    key_sifter u_sifter (
        .clk         (clk),
        .rst_n       (rst_n),
        .words       (words.sink),
        .key_wr_en   (key_wr_en),
        .key_addr    (key_addr),
        .key_wr_data (key_wr_data)
    );

endmodule

// File: design/key_sifter.sv
`include "sift_params.svh"

module key_sifter (
    input  logic clk,
    input  logic rst_n,
    qubit_word_if.sink words,
    output logic key_wr_en,
    output sift_types_pkg::mem_addr_t key_addr,
    output sift_types_pkg::key_word_t key_wr_data
);

    localparam int SLOTS = `SIFT_SLOTS;
    localparam int KEY_W = `SIFT_KEY_WIDTH;
    localparam int RING_W = 2 * KEY_W;
    localparam int OFS_W = $clog2(RING_W);
    localparam int CNT_W = $clog2(SLOTS + 1);

    sift_types_pkg::slot_mask_t keep;
    logic [CNT_W-1:0] idx [SLOTS];
    logic [OFS_W-1:0] pos [SLOTS];
    logic [CNT_W-1:0] kept_cnt;
    logic [OFS_W-1:0] offset;
    logic [OFS_W:0] offset_sum;
    logic cross_upper;
    logic cross_lower;
    logic [RING_W-1:0] ring;
    logic half_done;
    logic half_upper;

    // kept slots are ranked from slot 31 downwards
    always_comb begin
        keep = words.valid ? (words.notdecoy & words.detected) : '0;
        idx[SLOTS-1] = '0;
        for (int i = SLOTS - 2; i >= 0; i--) begin
            idx[i] = idx[i+1] + CNT_W'(keep[i+1]);
        end
        kept_cnt = idx[0] + CNT_W'(keep[0]);
        for (int i = 0; i < SLOTS; i++) begin
            pos[i] = OFS_W'(RING_W - 1) - offset - OFS_W'(idx[i]);
        end
    end

    assign offset_sum = {1'b0, offset} + (OFS_W + 1)'(kept_cnt);

    // at most 32 new bits, so only one half can complete per word
    assign cross_upper = !offset[OFS_W-1] && offset_sum[OFS_W-1];
    assign cross_lower = offset_sum[OFS_W];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            offset <= '0;
            half_done <= 1'b0;
        end else begin
            if (words.valid) begin
                offset <= offset_sum[OFS_W-1:0];
            end
            half_done <= cross_upper || cross_lower;
        end
    end

    always_ff @(posedge clk) begin
        half_upper <= cross_upper;
    end

    // key bit is the low pulse bit of the pair
    always_ff @(posedge clk) begin
        for (int i = 0; i < SLOTS; i++) begin
            if (keep[i]) begin
                ring[pos[i]] <= words.pulses[2*i];
            end
        end
    end

    // address starts at all ones so the first write lands on 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            key_wr_en <= 1'b0;
            key_addr <= '1;
        end else begin
            key_wr_en <= half_done;
            if (half_done) begin
                key_addr <= key_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        key_wr_data <= half_upper ? ring[RING_W-1:KEY_W] : ring[KEY_W-1:0];
    end

endmodule

// File: design/decoy_packet_writer.sv
module decoy_packet_writer (
    input  logic clk,
    input  logic rst_n,
    qubit_word_if.sink words,
    output logic tx_wr_en,
    output logic [31:0] tx_wr_data
);

    sift_packet_pkg::pkt_header_t header;

    always_comb begin
        header.pkt_type = sift_packet_pkg::PKT_TYPE_DECOY;
        header.pkt_length = sift_packet_pkg::PKT_LENGTH;
        // round number zero extended into the low half
        header.pkt_round = sift_packet_pkg::pkt_round_t'(words.round);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_wr_en <= 1'b0;
        end else begin
            tx_wr_en <= words.round_start || words.valid;
        end
    end

    // header first, then one mask per qubit word
    always_ff @(posedge clk) begin
        if (words.round_start) begin
            tx_wr_data <= header;
        end else begin
            tx_wr_data <= words.notdecoy;
        end
    end

endmodule

// File: design/qubit_reader.sv
`include "sift_params.svh"

module qubit_reader (
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    input  logic tx_empty,
    input  sift_types_pkg::qubit_word_t qubit_rdata,
    input  sift_types_pkg::slot_mask_t detected_rd_data,
    output sift_types_pkg::mem_addr_t qubit_addr,
    output logic detected_rd_en,
    output logic rounds_done,
    qubit_word_if.source words
);

    localparam int WORDS = `SIFT_WORDS_PER_ROUND;
    localparam int CNT_W = $clog2(WORDS + 1);

    sift_types_pkg::round_state_t state;
    sift_types_pkg::round_t round_cnt;
    logic [CNT_W-1:0] word_cnt;
    logic round_start_q;
    // address issued last cycle, memory answers now
    logic rd_q;
    logic valid_q;
    sift_types_pkg::qubit_word_t pulses_q;
    sift_types_pkg::slot_mask_t notdecoy;
    logic last_word;
    logic last_round;
    logic pipe_empty;

    assign last_word = (word_cnt == CNT_W'(WORDS - 1));
    assign last_round = (round_cnt == sift_types_pkg::round_t'(`SIFT_ROUNDS - 1));
    assign pipe_empty = !rd_q && !valid_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= sift_types_pkg::ROUND_IDLE;
            round_cnt <= '0;
            word_cnt <= '0;
            round_start_q <= 1'b0;
        end else begin
            round_start_q <= 1'b0;
            case (state)
                // tx fifo has to be drained before a new packet
                sift_types_pkg::ROUND_IDLE: begin
                    if (run && tx_empty) begin
                        state <= sift_types_pkg::ROUND_READ;
                        word_cnt <= '0;
                        round_start_q <= 1'b1;
                    end
                end
                sift_types_pkg::ROUND_READ: begin
                    word_cnt <= word_cnt + 1'b1;
                    if (last_word) begin
                        state <= sift_types_pkg::ROUND_DRAIN;
                    end
                end
                // let the words in flight reach the sinks
                sift_types_pkg::ROUND_DRAIN: begin
                    if (pipe_empty) begin
                        if (last_round) begin
                            state <= sift_types_pkg::ROUND_DONE;
                        end else begin
                            round_cnt <= round_cnt + 1'b1;
                            state <= sift_types_pkg::ROUND_IDLE;
                        end
                    end
                end
                sift_types_pkg::ROUND_DONE: begin
                    if (!run) begin
                        round_cnt <= '0;
                        state <= sift_types_pkg::ROUND_IDLE;
                    end
                end
                default: begin
                    state <= sift_types_pkg::ROUND_IDLE;
                end
            endcase
        end
    end

    // memory latency plus one register stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_q <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            rd_q <= (state == sift_types_pkg::ROUND_READ);
            valid_q <= rd_q;
        end
    end

    always_ff @(posedge clk) begin
        pulses_q <= qubit_rdata;
    end

    assign qubit_addr = sift_types_pkg::mem_addr_t'(round_cnt * WORDS + word_cnt);

    // decoy when both pulse bits of the slot are set
    always_comb begin
        for (int i = 0; i < `SIFT_SLOTS; i++) begin
            notdecoy[i] = ~(pulses_q[2*i+1] & pulses_q[2*i]);
        end
    end

    assign rounds_done = (state == sift_types_pkg::ROUND_DRAIN) && pipe_empty && last_round;

    // fwft fifo, pop together with the matching qubit word
    assign detected_rd_en = valid_q;

    assign words.round_start = round_start_q;
    assign words.round = round_cnt;
    assign words.valid = valid_q;
    assign words.pulses = pulses_q;
    assign words.notdecoy = notdecoy;
    assign words.detected = detected_rd_data;

endmodule

// File: design/sift_control.sv
module sift_control (
    input  logic clk,
    input  logic rst_n,
    input  logic start_sifting,
    input  logic start_tx,
    input  logic detect_fifo_full,
    input  logic rounds_done,
    output logic wait_tx,
    output logic run,
    output logic sifting_finish
);

    sift_types_pkg::sift_state_t state;
    sift_types_pkg::sift_state_t state_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= sift_types_pkg::SIFT_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            sift_types_pkg::SIFT_IDLE: begin
                if (start_sifting) begin
                    state_next = sift_types_pkg::SIFT_START;
                end
            end
            sift_types_pkg::SIFT_START: begin
                state_next = sift_types_pkg::SIFT_WAIT_FULL;
            end
            // receiver detection buffer must be complete first
            sift_types_pkg::SIFT_WAIT_FULL: begin
                if (detect_fifo_full) begin
                    state_next = sift_types_pkg::SIFT_WAIT_TX;
                end
            end
            // hold here until the link allows transmission
            sift_types_pkg::SIFT_WAIT_TX: begin
                if (start_tx) begin
                    state_next = sift_types_pkg::SIFT_RUN;
                end
            end
            sift_types_pkg::SIFT_RUN: begin
                if (rounds_done) begin
                    state_next = sift_types_pkg::SIFT_FINISH;
                end
            end
            sift_types_pkg::SIFT_FINISH: begin
                state_next = sift_types_pkg::SIFT_IDLE;
            end
            default: begin
                state_next = sift_types_pkg::SIFT_IDLE;
            end
        endcase
    end

    // outputs decoded from the state register
    assign wait_tx = (state == sift_types_pkg::SIFT_WAIT_TX);
    assign run = (state == sift_types_pkg::SIFT_RUN);
    assign sifting_finish = (state == sift_types_pkg::SIFT_FINISH);

endmodule

// File: design/qubit_word_if.sv
interface qubit_word_if;

    // first cycle of a round, round is valid with it
    logic round_start;
    sift_types_pkg::round_t round;

    // one qubit word with its masks, no back-pressure
    logic valid;
    sift_types_pkg::qubit_word_t pulses;
    sift_types_pkg::slot_mask_t notdecoy;
    sift_types_pkg::slot_mask_t detected;

    modport source (
        output round_start,
        output round,
        output valid,
        output pulses,
        output notdecoy,
        output detected
    );

    modport sink (
        input round_start,
        input round,
        input valid,
        input pulses,
        input notdecoy,
        input detected
    );

endinterface

// File: design/sift_packet_pkg.sv
`include "sift_params.svh"

package sift_packet_pkg;

    typedef logic [7:0] pkt_type_t;
    typedef logic [7:0] pkt_length_t;
    typedef logic [15:0] pkt_round_t;

    // header word, type in the top byte
    typedef struct packed {
        pkt_type_t pkt_type;
        pkt_length_t pkt_length;
        pkt_round_t pkt_round;
    } pkt_header_t;

    // decoy mask packet
    localparam pkt_type_t PKT_TYPE_DECOY = `SIFT_PKT_DECOY;

    // header plus one mask word per qubit word
    localparam pkt_length_t PKT_LENGTH = pkt_length_t'(`SIFT_PKT_LENGTH);

endpackage

// File: design/sift_types_pkg.sv
`include "sift_params.svh"

package sift_types_pkg;

    // pulse pairs, slot i on bits 2i+1 and 2i
    typedef logic [`SIFT_QUBIT_WIDTH-1:0] qubit_word_t;

    // one bit per time slot
    typedef logic [`SIFT_SLOTS-1:0] slot_mask_t;

    typedef logic [`SIFT_KEY_WIDTH-1:0] key_word_t;
    typedef logic [`SIFT_ADDR_WIDTH-1:0] mem_addr_t;
    typedef logic [`SIFT_ROUND_WIDTH-1:0] round_t;

    // run level sequencing
    typedef enum logic [2:0] {
        SIFT_IDLE,
        SIFT_START,
        SIFT_WAIT_FULL,
        SIFT_WAIT_TX,
        SIFT_RUN,
        SIFT_FINISH
    } sift_state_t;

    // per round sequencing inside the reader
    typedef enum logic [1:0] {
        ROUND_IDLE,
        ROUND_READ,
        ROUND_DRAIN,
        ROUND_DONE
    } round_state_t;

endpackage

// File: include/sift_params.svh
`ifndef SIFT_PARAMS_SVH
`define SIFT_PARAMS_SVH

// one qubit word holds 32 slots of two pulse bits
`define SIFT_QUBIT_WIDTH 64
`define SIFT_SLOTS 32

// sifted key words and memory addressing
`define SIFT_KEY_WIDTH 64
`define SIFT_ADDR_WIDTH 15
`define SIFT_ROUND_WIDTH 8

// round geometry, small so that simulation stays short
`define SIFT_WORDS_PER_ROUND 16
`define SIFT_ROUNDS 4

// tx packet header codes
`define SIFT_PKT_DECOY 8'hd5
`define SIFT_PKT_LENGTH (`SIFT_WORDS_PER_ROUND + 1)

`endif
